// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= mem_island_tb
RTL_TOP    ?= mem_island_top
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   := Test failed
PASS_MSG   := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bank_arbiter.sv ====
// Narrow/wide arbiter in front of one SRAM bank
// Narrow has priority until a run of conflicts reaches the wait limit,
// then wide gets the bank for one cycle

`include "mem_island_settings.svh"

`default_nettype none

module bank_arbiter
  import mem_island_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   narrow_req_i,
  input  wire bank_req_t              narrow_pld_i,
  input  wire logic                   wide_req_i,
  input  wire bank_req_t              wide_pld_i,
  output logic                        narrow_gnt_o,
  output logic                        wide_gnt_o,
  output logic [`MI_NARROW_WIDTH-1:0] rdata_o
);

  localparam int unsigned PRIO_WAIT = `MI_PRIO_WAIT;
  localparam int unsigned CNT_W     = $clog2(PRIO_WAIT + 1);

  logic [CNT_W-1:0] wait_cnt_d;
  logic [CNT_W-1:0] wait_cnt_q;
  logic             conflict;
  logic             yield;
  logic             narrow_sel;
  logic             bank_req;
  bank_req_t        bank_pld;

  assign conflict = narrow_req_i & wide_req_i;
  assign yield    = conflict & (wait_cnt_q == CNT_W'(PRIO_WAIT));

  assign narrow_sel   = narrow_req_i & ~yield;
  assign narrow_gnt_o = narrow_sel;
  assign wide_gnt_o   = wide_req_i & ~narrow_sel;

  // Counts a run of conflicts, cleared by a yield or a quiet cycle
  always_comb begin
    wait_cnt_d = '0;
    if (conflict && !yield) begin
      wait_cnt_d = wait_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_cnt_q <= '0;
    end else begin
      wait_cnt_q <= wait_cnt_d;
    end
  end

  assign bank_req = narrow_req_i | wide_req_i;
  assign bank_pld = narrow_sel ? narrow_pld_i : wide_pld_i;

  // rdata goes to both ports, each router tracks its own ownership
  sram_bank sram_bank_i (
    .clk_i   (clk_i),
    .req_i   (bank_req),
    .pld_i   (bank_pld),
    .rdata_o (rdata_o)
  );

endmodule

`default_nettype wire

// ==== mem_island_pkg.sv ====
// Shared types of the scratchpad memory island
// Opcode, bank index types and the request payloads of both ports

`include "mem_island_settings.svh"

`default_nettype none

package mem_island_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  // Word within one bank, and flat bank number
  typedef logic [$clog2(`MI_WORDS_PER_BANK)-1:0] bank_addr_t;
  typedef logic [$clog2(`MI_NUM_BANKS)-1:0]      bank_idx_t;

  typedef struct packed {
    logic [`MI_ADDR_WIDTH-1:0]     addr;
    mem_op_e                       op;
    logic [`MI_NARROW_WIDTH-1:0]   wdata;
    logic [`MI_NARROW_WIDTH/8-1:0] strb;
  } narrow_req_t;

  typedef struct packed {
    logic [`MI_ADDR_WIDTH-1:0]   addr;
    mem_op_e                     op;
    logic [`MI_WIDE_WIDTH-1:0]   wdata;
    logic [`MI_WIDE_WIDTH/8-1:0] strb;
  } wide_req_t;

  // What a single SRAM bank sees
  typedef struct packed {
    bank_addr_t                    addr;
    mem_op_e                       op;
    logic [`MI_NARROW_WIDTH-1:0]   wdata;
    logic [`MI_NARROW_WIDTH/8-1:0] strb;
  } bank_req_t;

endpackage

`default_nettype wire

// ==== mem_island_props.sv ====
// Handshake timing checks on the memory island top level
// Bound into the top level, one set of rules per port

`default_nettype none

module mem_island_props
  import mem_island_pkg::*;
(
  input wire logic        clk_i,
  input wire logic        rst_ni,
  input wire logic        narrow_req_i,
  input wire narrow_req_t narrow_pld_i,
  input wire logic        narrow_gnt_i,
  input wire logic        narrow_rvalid_i,
  input wire logic        wide_req_i,
  input wire wide_req_t   wide_pld_i,
  input wire logic        wide_gnt_i,
  input wire logic        wide_rvalid_i
);

  int unsigned fail_cnt = 0;

  // A grant only answers a request
  a_narrow_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    narrow_gnt_i |-> narrow_req_i)
    else begin fail_cnt++; $error("narrow grant without request"); end
  a_wide_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wide_gnt_i |-> wide_req_i)
    else begin fail_cnt++; $error("wide grant without request"); end

  // Response exactly one cycle after each transfer
  a_narrow_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    narrow_rvalid_i == $past(narrow_req_i && narrow_gnt_i))
    else begin fail_cnt++; $error("narrow rvalid does not follow the transfer"); end
  a_wide_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wide_rvalid_i == $past(wide_req_i && wide_gnt_i))
    else begin fail_cnt++; $error("wide rvalid does not follow the transfer"); end

  a_rvalid_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !narrow_rvalid_i && !wide_rvalid_i)
    else begin fail_cnt++; $error("rvalid high right after reset"); end

  // Requester holds its payload until granted
  a_narrow_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (narrow_req_i && !narrow_gnt_i) |=> narrow_req_i && $stable(narrow_pld_i))
    else begin fail_cnt++; $error("narrow request changed before grant"); end
  a_wide_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wide_req_i && !wide_gnt_i) |=> wide_req_i && $stable(wide_pld_i))
    else begin fail_cnt++; $error("wide request changed before grant"); end

endmodule

`default_nettype wire

// ==== mem_island_settings.svh ====
// Build-time settings of the scratchpad memory island
// Widths, banking and the narrow-over-wide priority wait

`ifndef MEM_ISLAND_SETTINGS_SVH
`define MEM_ISLAND_SETTINGS_SVH

// Byte address and port data widths
`define MI_ADDR_WIDTH     10
`define MI_NARROW_WIDTH   32
`define MI_WIDE_WIDTH     64

// Banking
`define MI_NUM_WIDE_BANKS 2
`define MI_WORDS_PER_BANK 64

// Conflict cycles before narrow gives one cycle to wide
`define MI_PRIO_WAIT      3

// Derived
`define MI_SUB_BANKS      (`MI_WIDE_WIDTH / `MI_NARROW_WIDTH)
`define MI_NUM_BANKS      (`MI_NUM_WIDE_BANKS * `MI_SUB_BANKS)

`endif

// ==== mem_island_tb.sv ====
// Testbench for the scratchpad memory island
// LFSR driven narrow and wide traffic checked against a byte model and a
// per-bank arbitration model

`include "mem_island_settings.svh"

`default_nettype none

module mem_island_tb
  import mem_island_pkg::*;
();

  typedef logic [`MI_ADDR_WIDTH-1:0] addr_t;

  localparam int unsigned NUM_CYCLES = 4000;
  localparam int unsigned HOLD_LIMIT = 64;
  localparam int unsigned FILL_WORDS = 8;
  localparam int unsigned PRIO_WAIT  = `MI_PRIO_WAIT;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        narrow_req_i;
  narrow_req_t                 narrow_pld_i;
  logic                        narrow_gnt_o;
  logic                        narrow_rvalid_o;
  logic [`MI_NARROW_WIDTH-1:0] narrow_rdata_o;
  logic                        wide_req_i;
  wide_req_t                   wide_pld_i;
  logic                        wide_gnt_o;
  logic                        wide_rvalid_o;
  logic [`MI_WIDE_WIDTH-1:0]   wide_rdata_o;

  logic [31:0]                 lfsr_q;
  int unsigned                 model_err = 0;
  int unsigned                 stim_err = 0;
  logic [7:0]                  mem_model [2**`MI_ADDR_WIDTH];
  int unsigned                 wait_model [`MI_NUM_BANKS];
  logic                        n_xfer;
  logic                        w_xfer;
  logic                        n_pend;
  logic                        n_pend_rd;
  logic                        w_pend;
  logic                        w_pend_rd;
  logic [`MI_NARROW_WIDTH-1:0] n_exp;
  logic [`MI_WIDE_WIDTH-1:0]   w_exp;

  mem_island_top mem_island_top_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .narrow_req_i    (narrow_req_i),
    .narrow_pld_i    (narrow_pld_i),
    .narrow_gnt_o    (narrow_gnt_o),
    .narrow_rvalid_o (narrow_rvalid_o),
    .narrow_rdata_o  (narrow_rdata_o),
    .wide_req_i      (wide_req_i),
    .wide_pld_i      (wide_pld_i),
    .wide_gnt_o      (wide_gnt_o),
    .wide_rvalid_o   (wide_rvalid_o),
    .wide_rdata_o    (wide_rdata_o)
  );

  bind mem_island_top mem_island_props mem_island_props_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .narrow_req_i    (narrow_req_i),
    .narrow_pld_i    (narrow_pld_i),
    .narrow_gnt_i    (narrow_gnt_o),
    .narrow_rvalid_i (narrow_rvalid_o),
    .wide_req_i      (wide_req_i),
    .wide_pld_i      (wide_pld_i),
    .wide_gnt_i      (wide_gnt_o),
    .wide_rvalid_i   (wide_rvalid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Galois LFSR, one step for every bit taken
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_q[0]};
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  // Word index limited to the filled words so reads hit known data
  function automatic narrow_req_t random_narrow();
    narrow_req_t r;
    r.addr  = addr_t'(rand_bits(7));
    r.op    = (rand_bits(1) != 64'd0) ? OP_WRITE : OP_READ;
    r.wdata = 32'(rand_bits(32));
    r.strb  = 4'(rand_bits(4));
    return r;
  endfunction

  function automatic wide_req_t random_wide();
    wide_req_t r;
    r.addr  = addr_t'(rand_bits(7));
    r.op    = (rand_bits(1) != 64'd0) ? OP_WRITE : OP_READ;
    r.wdata = rand_bits(64);
    r.strb  = 8'(rand_bits(8));
    return r;
  endfunction

  function automatic wide_req_t fill_req(input addr_t a);
    wide_req_t r;
    r.addr  = a;
    r.op    = OP_WRITE;
    r.wdata = {22'h2b3c1d, a | addr_t'(4), 22'h1a2f0e, a};
    r.strb  = '1;
    return r;
  endfunction

  // Reference model, evaluated mid-cycle while inputs and grants are stable
  always @(negedge clk_i) begin : model_check
    bank_idx_t                n_bank;
    logic                     w_bank;
    logic                     nr;
    logic                     wr;
    logic                     conf;
    logic                     yl;
    logic [`MI_NUM_BANKS-1:0] n_win;
    logic [`MI_NUM_BANKS-1:0] w_win;
    logic                     exp_n_gnt;
    logic                     exp_w_gnt;
    addr_t                    base;
    if (!rst_ni) begin
      n_xfer = 1'b0;
      w_xfer = 1'b0;
      n_pend = 1'b0;
      w_pend = 1'b0;
      for (int b = 0; b < `MI_NUM_BANKS; b++) begin
        wait_model[b] = 0;
      end
    end else begin
      assert (narrow_rvalid_o === n_pend) else begin
        model_err++;
        $display("ERROR narrow_rvalid_o: got %h expected %h", narrow_rvalid_o, n_pend);
      end
      assert (wide_rvalid_o === w_pend) else begin
        model_err++;
        $display("ERROR wide_rvalid_o: got %h expected %h", wide_rvalid_o, w_pend);
      end
      if (n_pend && n_pend_rd) begin
        assert (narrow_rdata_o === n_exp) else begin
          model_err++;
          $display("ERROR narrow_rdata_o: got %h expected %h", narrow_rdata_o, n_exp);
        end
      end
      if (w_pend && w_pend_rd) begin
        assert (wide_rdata_o === w_exp) else begin
          model_err++;
          $display("ERROR wide_rdata_o: got %h expected %h", wide_rdata_o, w_exp);
        end
      end

      // Narrow wins a bank unless its run of conflicts has reached the wait
      n_bank = narrow_pld_i.addr[3:2];
      w_bank = wide_pld_i.addr[3];
      for (int b = 0; b < `MI_NUM_BANKS; b++) begin
        nr = narrow_req_i && (n_bank == bank_idx_t'(b));
        wr = wide_req_i && ((b / 2) == int'(w_bank));
        conf = nr && wr;
        yl = conf && (wait_model[b] == PRIO_WAIT);
        n_win[b] = nr && !yl;
        w_win[b] = wr && !n_win[b];
        wait_model[b] = (conf && !yl) ? wait_model[b] + 1 : 0;
      end
      exp_n_gnt = narrow_req_i && n_win[n_bank];
      exp_w_gnt = wide_req_i && w_win[{w_bank, 1'b0}] && w_win[{w_bank, 1'b1}];
      assert (narrow_gnt_o === exp_n_gnt) else begin
        model_err++;
        $display("ERROR narrow_gnt_o: got %h expected %h", narrow_gnt_o, exp_n_gnt);
      end
      assert (wide_gnt_o === exp_w_gnt) else begin
        model_err++;
        $display("ERROR wide_gnt_o: got %h expected %h", wide_gnt_o, exp_w_gnt);
      end

      // Apply transfers, narrow first
      n_xfer = narrow_req_i && narrow_gnt_o;
      w_xfer = wide_req_i && wide_gnt_o;
      n_pend = n_xfer;
      n_pend_rd = n_xfer && (narrow_pld_i.op == OP_READ);
      w_pend = w_xfer;
      w_pend_rd = w_xfer && (wide_pld_i.op == OP_READ);
      if (n_xfer) begin
        base = {narrow_pld_i.addr[9:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
          n_exp[i*8 +: 8] = mem_model[base + addr_t'(i)];
          if (narrow_pld_i.op == OP_WRITE && narrow_pld_i.strb[i]) begin
            mem_model[base + addr_t'(i)] = narrow_pld_i.wdata[i*8 +: 8];
          end
        end
      end
      if (w_xfer) begin
        base = {wide_pld_i.addr[9:3], 3'b000};
        for (int i = 0; i < 8; i++) begin
          w_exp[i*8 +: 8] = mem_model[base + addr_t'(i)];
          if (wide_pld_i.op == OP_WRITE && wide_pld_i.strb[i]) begin
            mem_model[base + addr_t'(i)] = wide_pld_i.wdata[i*8 +: 8];
          end
        end
      end
    end
  end

  initial begin : stimulus
    int unsigned waited;
    int unsigned n_hold;
    int unsigned w_hold;
    int unsigned prop_err;
    addr_t       fill_addr;
    lfsr_q       = 32'd36;
    rst_ni       = 1'b0;
    narrow_req_i = 1'b0;
    narrow_pld_i = '0;
    wide_req_i   = 1'b0;
    wide_pld_i   = '0;
    n_hold       = 0;
    w_hold       = 0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // Wide writes give every reachable word a known value
    for (int w = 0; w < 2 * FILL_WORDS; w++) begin
      fill_addr = addr_t'(w * 8);
      wide_req_i <= 1'b1;
      wide_pld_i <= fill_req(fill_addr);
      waited = 0;
      do begin
        @(posedge clk_i);
        waited++;
      end while (!w_xfer && waited < HOLD_LIMIT);
      assert (w_xfer) else begin
        stim_err++;
        $display("ERROR: fill write to address %h was not granted in time", fill_addr);
      end
    end

    for (int c = 0; c < NUM_CYCLES; c++) begin
      if (!narrow_req_i || n_xfer) begin
        n_hold = 0;
        narrow_req_i <= (rand_bits(2) != 64'd0);
        narrow_pld_i <= random_narrow();
      end else begin
        n_hold++;
        assert (n_hold != HOLD_LIMIT) else begin
          stim_err++;
          $display("ERROR: narrow request held too long without a grant");
        end
      end
      if (!wide_req_i || w_xfer) begin
        w_hold = 0;
        wide_req_i <= (rand_bits(1) != 64'd0);
        wide_pld_i <= random_wide();
      end else begin
        w_hold++;
        assert (w_hold != HOLD_LIMIT) else begin
          stim_err++;
          $display("ERROR: wide request held too long without a grant");
        end
      end
      @(posedge clk_i);
    end

    // Let open requests finish, then one more model pass for the last response
    waited = 0;
    while ((narrow_req_i || wide_req_i) && waited < HOLD_LIMIT) begin
      if (n_xfer) begin
        narrow_req_i <= 1'b0;
      end
      if (w_xfer) begin
        wide_req_i <= 1'b0;
      end
      @(posedge clk_i);
      waited++;
    end
    assert (!narrow_req_i && !wide_req_i) else begin
      stim_err++;
      $display("ERROR: requests were still open at the end of the run");
    end
    @(negedge clk_i);

    prop_err = mem_island_top_i.mem_island_props_i.fail_cnt;
    $display("Errors: model %0d, stimulus %0d, assertions %0d", model_err, stim_err, prop_err);
    if (model_err + stim_err + prop_err == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mem_island_top.sv ====
// Scratchpad memory island top level
// One narrow and one wide port over four arbitrated 32-bit SRAM banks,
// fixed one-cycle response latency on both ports

`include "mem_island_settings.svh"

`default_nettype none

module mem_island_top
  import mem_island_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   narrow_req_i,
  input  wire narrow_req_t            narrow_pld_i,
  output logic                        narrow_gnt_o,
  output logic                        narrow_rvalid_o,
  output logic [`MI_NARROW_WIDTH-1:0] narrow_rdata_o,
  input  wire logic                   wide_req_i,
  input  wire wide_req_t              wide_pld_i,
  output logic                        wide_gnt_o,
  output logic                        wide_rvalid_o,
  output logic [`MI_WIDE_WIDTH-1:0]   wide_rdata_o
);

  localparam int unsigned NB   = `MI_NUM_BANKS;
  localparam int unsigned SUB  = `MI_SUB_BANKS;
  localparam int unsigned NW   = `MI_NARROW_WIDTH;
  localparam int unsigned WB_W = $clog2(`MI_NUM_WIDE_BANKS);

  logic [NB-1:0]         n_req;
  bank_req_t [NB-1:0]    n_pld;
  logic [NB-1:0]         n_gnt;
  logic [NB-1:0]         w_req;
  bank_req_t [NB-1:0]    w_pld;
  logic [NB-1:0]         w_gnt;
  logic [NB-1:0][NW-1:0] bank_rdata;
  logic [SUB-1:0]        sub_req;
  bank_req_t [SUB-1:0]   sub_pld;
  logic [SUB-1:0]        sub_gnt;
  logic [WB_W-1:0]       wide_bank;

  narrow_router narrow_router_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .narrow_req_i    (narrow_req_i),
    .narrow_pld_i    (narrow_pld_i),
    .narrow_gnt_o    (narrow_gnt_o),
    .narrow_rvalid_o (narrow_rvalid_o),
    .narrow_rdata_o  (narrow_rdata_o),
    .bank_req_o      (n_req),
    .bank_pld_o      (n_pld),
    .bank_gnt_i      (n_gnt),
    .bank_rdata_i    (bank_rdata)
  );

  wide_splitter wide_splitter_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wide_req_i    (wide_req_i),
    .wide_pld_i    (wide_pld_i),
    .wide_gnt_o    (wide_gnt_o),
    .wide_rvalid_o (wide_rvalid_o),
    .wide_rdata_o  (wide_rdata_o),
    .sub_req_o     (sub_req),
    .sub_pld_o     (sub_pld),
    .sub_gnt_i     (sub_gnt),
    .wide_bank_o   (wide_bank),
    .bank_rdata_i  (bank_rdata)
  );

  // Flat bank b is sub-bank b % SUB of wide bank b / SUB
  for (genvar b = 0; b < NB; b++) begin : gen_banks
    localparam logic [WB_W-1:0] WB = WB_W'(b / SUB);
    localparam int unsigned     SB = b % SUB;

    assign w_req[b] = sub_req[SB] && (wide_bank == WB);
    assign w_pld[b] = sub_pld[SB];

    bank_arbiter bank_arbiter_i (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .narrow_req_i (n_req[b]),
      .narrow_pld_i (n_pld[b]),
      .wide_req_i   (w_req[b]),
      .wide_pld_i   (w_pld[b]),
      .narrow_gnt_o (n_gnt[b]),
      .wide_gnt_o   (w_gnt[b]),
      .rdata_o      (bank_rdata[b])
    );
  end

  // Grants back from the arbiters of the targeted wide bank
  always_comb begin
    for (int s = 0; s < SUB; s++) begin
      sub_gnt[s] = w_gnt[bank_idx_t'(wide_bank * SUB + s)];
    end
  end

endmodule

`default_nettype wire

// ==== narrow_router.sv ====
// Narrow port router
// Decodes the sub-bank and wide-bank bits to one of the four banks and
// picks that bank's read data in the cycle after the transfer

`include "mem_island_settings.svh"

`default_nettype none

module narrow_router
  import mem_island_pkg::*;
(
  input  wire logic                                         clk_i,
  input  wire logic                                         rst_ni,
  input  wire logic                                         narrow_req_i,
  input  wire narrow_req_t                                  narrow_pld_i,
  output logic                                              narrow_gnt_o,
  output logic                                              narrow_rvalid_o,
  output logic [`MI_NARROW_WIDTH-1:0]                       narrow_rdata_o,
  output logic [`MI_NUM_BANKS-1:0]                          bank_req_o,
  output bank_req_t [`MI_NUM_BANKS-1:0]                     bank_pld_o,
  input  wire logic [`MI_NUM_BANKS-1:0]                     bank_gnt_i,
  input  wire logic [`MI_NUM_BANKS-1:0][`MI_NARROW_WIDTH-1:0] bank_rdata_i
);

  // Bank select sits right above the byte offset, word index above that
  localparam int unsigned SEL_LSB  = $clog2(`MI_NARROW_WIDTH / 8);
  localparam int unsigned ADDR_LSB = SEL_LSB + $clog2(`MI_NUM_BANKS);

  bank_idx_t  bank_sel;
  bank_addr_t bank_addr;
  logic       xfer;
  logic       rvalid_q;
  bank_idx_t  bank_sel_q;

  assign bank_sel  = narrow_pld_i.addr[SEL_LSB +: $bits(bank_idx_t)];
  assign bank_addr = narrow_pld_i.addr[ADDR_LSB +: $bits(bank_addr_t)];

  always_comb begin
    for (int b = 0; b < `MI_NUM_BANKS; b++) begin
      bank_req_o[b]       = narrow_req_i && (bank_sel == bank_idx_t'(b));
      bank_pld_o[b].addr  = bank_addr;
      bank_pld_o[b].op    = narrow_pld_i.op;
      bank_pld_o[b].wdata = narrow_pld_i.wdata;
      bank_pld_o[b].strb  = narrow_pld_i.strb;
    end
  end

  assign narrow_gnt_o = bank_gnt_i[bank_sel];
  assign xfer         = narrow_req_i & narrow_gnt_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q   <= 1'b0;
      bank_sel_q <= '0;
    end else begin
      rvalid_q <= xfer;
      if (xfer) begin
        bank_sel_q <= bank_sel;
      end
    end
  end

  assign narrow_rvalid_o = rvalid_q;
  assign narrow_rdata_o  = bank_rdata_i[bank_sel_q];

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
mem_island_pkg.sv
sram_bank.sv
bank_arbiter.sv
narrow_router.sv
wide_splitter.sv
mem_island_top.sv
mem_island_props.sv
mem_island_tb.sv

// ==== sram_bank.sv ====
// Single-port scratchpad SRAM bank
// Byte-strobed writes, read data registered one cycle after the request

`include "mem_island_settings.svh"

`default_nettype none

module sram_bank
  import mem_island_pkg::*;
(
  input  wire logic                        clk_i,
  input  wire logic                        req_i,
  input  wire bank_req_t                   pld_i,
  output logic [`MI_NARROW_WIDTH-1:0]      rdata_o
);

  localparam int unsigned NUM_BYTES = `MI_NARROW_WIDTH / 8;

  logic [`MI_NARROW_WIDTH-1:0] mem_q [`MI_WORDS_PER_BANK];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (pld_i.op == OP_WRITE) begin
        // Only strobed bytes change
        for (int b = 0; b < NUM_BYTES; b++) begin
          if (pld_i.strb[b]) begin
            mem_q[pld_i.addr][b*8 +: 8] <= pld_i.wdata[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[pld_i.addr];
      end
    end
  end

endmodule

`default_nettype wire

// ==== wide_splitter.sv ====
// Wide port splitter
// Cuts a wide access into one narrow access per sub-bank of the chosen
// wide bank, grants only when every sub-bank grants in the same cycle

`include "mem_island_settings.svh"

`default_nettype none

module wide_splitter
  import mem_island_pkg::*;
(
  input  wire logic                                         clk_i,
  input  wire logic                                         rst_ni,
  input  wire logic                                         wide_req_i,
  input  wire wide_req_t                                    wide_pld_i,
  output logic                                              wide_gnt_o,
  output logic                                              wide_rvalid_o,
  output logic [`MI_WIDE_WIDTH-1:0]                         wide_rdata_o,
  output logic [`MI_SUB_BANKS-1:0]                          sub_req_o,
  output bank_req_t [`MI_SUB_BANKS-1:0]                     sub_pld_o,
  input  wire logic [`MI_SUB_BANKS-1:0]                     sub_gnt_i,
  output logic [$clog2(`MI_NUM_WIDE_BANKS)-1:0]             wide_bank_o,
  input  wire logic [`MI_NUM_BANKS-1:0][`MI_NARROW_WIDTH-1:0] bank_rdata_i
);

  localparam int unsigned NW       = `MI_NARROW_WIDTH;
  localparam int unsigned SUB      = `MI_SUB_BANKS;
  localparam int unsigned WB_W     = $clog2(`MI_NUM_WIDE_BANKS);
  localparam int unsigned WB_LSB   = $clog2(`MI_WIDE_WIDTH / 8);
  localparam int unsigned ADDR_LSB = WB_LSB + WB_W;

  logic            all_gnt;
  logic            xfer;
  logic            rvalid_q;
  logic [WB_W-1:0] wbank_q;

  assign wide_bank_o = wide_pld_i.addr[WB_LSB +: WB_W];
  assign all_gnt     = &sub_gnt_i;
  assign wide_gnt_o  = wide_req_i & all_gnt;
  assign xfer        = wide_req_i & wide_gnt_o;

  // Sub-bank 0 carries the low half
  always_comb begin
    for (int s = 0; s < SUB; s++) begin
      sub_req_o[s]      = wide_req_i;
      sub_pld_o[s].addr = wide_pld_i.addr[ADDR_LSB +: $bits(bank_addr_t)];
      // A half may win its bank alone, so the write waits for both grants
      sub_pld_o[s].op    = (wide_pld_i.op == OP_WRITE && all_gnt) ? OP_WRITE : OP_READ;
      sub_pld_o[s].wdata = wide_pld_i.wdata[s*NW +: NW];
      sub_pld_o[s].strb  = wide_pld_i.strb[s*(NW/8) +: NW/8];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      wbank_q  <= '0;
    end else begin
      rvalid_q <= xfer;
      if (xfer) begin
        wbank_q <= wide_bank_o;
      end
    end
  end

  assign wide_rvalid_o = rvalid_q;

  always_comb begin
    for (int s = 0; s < SUB; s++) begin
      wide_rdata_o[s*NW +: NW] = bank_rdata_i[bank_idx_t'(wbank_q * SUB + s)];
    end
  end

endmodule

`default_nettype wire
